// File: rtl/selftest_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Power-on self-test constants
// Checker counts, run lengths, RAM size and clock window limits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SELFTEST_DEFS_SVH
`define SELFTEST_DEFS_SVH

// Arithmetic, memory, clock
`define SELFTEST_NUM_CHECKS 3

// Multiplications per arithmetic run
`define ARITH_ITERS 32
// Start value of the operand LFSR, never zero
`define LFSR_SEED 32'h1d2c_3b4a

// RAM depth is 2**MEM_ADDR_BITS
`define MEM_ADDR_BITS 6

// Clock window in clk cycles, expected fastclk edges per clk, allowed error
`define CLK_WIN 64
`define FAST_RATIO 4
`define FAST_TOL 8

// Longest run from start to done, set by the arithmetic checker
`define SELFTEST_MAX_CYCLES 600

`endif

// File: rtl/selftest_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-test control types
// Sequencer states and the per-checker status and inject vectors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "selftest_defs.svh"

package selftest_pkg;

   // Sequencer states
   typedef enum logic [1:0] {
      idle,
      run,
      report
   } ctrl_state_t;

   // One passed bit per checker
   // Bit 0 arithmetic, bit 1 memory, bit 2 clock
   typedef logic [`SELFTEST_NUM_CHECKS-1:0] check_status_t;

   // One fault-inject bit per checker, same bit order as status
   typedef logic [`SELFTEST_NUM_CHECKS-1:0] inject_mask_t;

endpackage

`default_nettype wire

// File: rtl/datapath_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-test datapath types
// Multiplier operands, LFSR state and on-chip RAM address and word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "selftest_defs.svh"

package datapath_pkg;

   typedef logic [15:0] word_t;
   typedef logic [31:0] prod_t;
   typedef logic [31:0] lfsr_t;

   // Test RAM
   typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;
   typedef logic [15:0] mem_word_t;

endpackage

`default_nettype wire

// File: rtl/check_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker link
// Start pulse and inject bit out, done and passed levels back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

interface check_if;

   // One-clk launch pulse, inject sampled with it
   logic start;
   logic inject;
   // Held from end of run until next start
   logic done;
   logic passed;

   modport ctrl (output start, output inject, input done, input passed);

   // Checker side
   modport check (input start, input inject, output done, output passed);

endinterface

`default_nettype wire

// File: rtl/arith_check.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic checker
// Shift-add multiplier compared against a direct product on LFSR operands
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "selftest_defs.svh"

module arith_check
   import datapath_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   check_if.check chk
);

   localparam int ITER_BITS = $clog2(`ARITH_ITERS + 1);
   // Step 0 loads, 1..16 shift-add, 17 compares
   localparam logic [4:0] LAST_STEP = 5'd17;

   lfsr_t                lfsr;
   lfsr_t                lfsr_nx;
   word_t                op_a;
   word_t                op_b;
   word_t                mplier;
   prod_t                mcand;
   prod_t                acc;
   prod_t                shift_add;
   prod_t                direct;
   logic [4:0]           step;
   logic [ITER_BITS-1:0] iter;
   logic                 running;
   logic                 inj;
   logic                 pass_q;
   logic                 done_q;

   // Galois LFSR, taps 32 22 2 1
   assign lfsr_nx = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);

   // Fault flips the low product bit
   assign shift_add = {acc[31:1], acc[0] ^ inj};
   assign direct    = prod_t'(op_a) * prod_t'(op_b);

   // Operand and multiplier datapath
   always_ff @(posedge clk) begin
      if (chk.start) begin
         lfsr <= `LFSR_SEED;
      end else if (running) begin
         lfsr <= lfsr_nx;
      end
      if (running) begin
         if (step == 5'd0) begin
            op_a   <= lfsr[15:0];
            op_b   <= lfsr[31:16];
            mcand  <= {16'h0, lfsr[15:0]};
            mplier <= lfsr[31:16];
            acc    <= '0;
         end else if (step != LAST_STEP) begin
            // One multiplier bit per cycle, LSB first
            if (mplier[0]) begin
               acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
         end
      end
   end

   // Iteration and result control
   always_ff @(posedge clk) begin
      if (reset) begin
         running <= 1'b0;
         done_q  <= 1'b0;
         pass_q  <= 1'b0;
         inj     <= 1'b0;
         iter    <= '0;
         step    <= '0;
      end else if (chk.start) begin
         running <= 1'b1;
         done_q  <= 1'b0;
         pass_q  <= 1'b1;
         inj     <= chk.inject;
         iter    <= '0;
         step    <= '0;
      end else if (running) begin
         if (step == LAST_STEP) begin
            step <= '0;
            iter <= iter + 1'b1;
            // Sticky until next start
            if (shift_add != direct) begin
               pass_q <= 1'b0;
            end
            if (iter == ITER_BITS'(`ARITH_ITERS - 1)) begin
               running <= 1'b0;
               done_q  <= 1'b1;
            end
         end else begin
            step <= step + 1'b1;
         end
      end
   end

   assign chk.done   = done_q;
   assign chk.passed = pass_q;

   // Run never overshoots, and done only follows a full run
   a_iter_bound: assert property (@(posedge clk) disable iff (reset)
      iter <= `ARITH_ITERS && (!chk.done || iter == `ARITH_ITERS));

endmodule

`default_nettype wire

// File: rtl/mem_check.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory checker
// Four-pass march test over a small inferred single-port RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "selftest_defs.svh"

module mem_check
   import datapath_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   check_if.check chk
);

   localparam int        DEPTH   = 2 ** `MEM_ADDR_BITS;
   localparam mem_word_t PATTERN = 16'h5a5a;

   mem_word_t  mem [DEPTH];
   mem_addr_t  addr;
   // Pass 0 write up, 1 read up, 2 write inverse down, 3 read down
   logic [1:0] pass_idx;
   logic [1:0] drain;
   mem_word_t  pat;
   mem_word_t  pat_sel;
   mem_word_t  wdata;
   mem_word_t  rdata;
   mem_word_t  exp_q;
   logic       we;
   logic       rd;
   logic       rd_vld;
   logic       last_addr;
   logic       running;
   logic       inj;
   logic       pass_q;
   logic       done_q;

   assign pat     = mem_word_t'(addr) ^ PATTERN;
   assign pat_sel = pass_idx[1] ? ~pat : pat;
   // Odd passes read
   assign we      = running && !pass_idx[0];
   assign rd      = running && pass_idx[0];

   // Fault lands on address 0 of the first write pass only
   assign wdata = pat_sel ^ mem_word_t'(inj && !pass_idx[1] && addr == '0);

   assign last_addr = pass_idx[1] ? (addr == '0) : (addr == '1);

   // Single-port array, registered read
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
      exp_q <= pat_sel;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         running  <= 1'b0;
         done_q   <= 1'b0;
         pass_q   <= 1'b0;
         inj      <= 1'b0;
         addr     <= '0;
         pass_idx <= '0;
         rd_vld   <= 1'b0;
         drain    <= '0;
      end else if (chk.start) begin
         running  <= 1'b1;
         done_q   <= 1'b0;
         pass_q   <= 1'b1;
         inj      <= chk.inject;
         addr     <= '0;
         pass_idx <= '0;
         rd_vld   <= 1'b0;
         drain    <= '0;
      end else begin
         rd_vld <= rd;
         // Compare one cycle after the read
         if (rd_vld && rdata != exp_q) begin
            pass_q <= 1'b0;
         end
         // Tail of two cycles lets the last compare land
         if (drain != 2'd0) begin
            drain <= drain - 2'd1;
            if (drain == 2'd1) begin
               done_q <= 1'b1;
            end
         end
         if (running) begin
            if (last_addr) begin
               pass_idx <= pass_idx + 2'd1;
               if (pass_idx == 2'd3) begin
                  running <= 1'b0;
                  drain   <= 2'd2;
               end else begin
                  // Only pass 1 starts at the bottom again
                  addr <= (pass_idx == 2'd0) ? '0 : '1;
               end
            end else if (pass_idx[1]) begin
               addr <= addr - 1'b1;
            end else begin
               addr <= addr + 1'b1;
            end
         end
      end
   end

   assign chk.done   = done_q;
   assign chk.passed = pass_q;

   // Word read in a read pass is still in the array a cycle later
   a_no_write_in_read: assert property (@(posedge clk) disable iff (reset)
      rd |=> rdata == mem[$past(addr)]);

endmodule

`default_nettype wire

// File: rtl/clk_check.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock checker
// Counts fastclk edges over a clk window through a Gray-coded crossing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "selftest_defs.svh"

module clk_check (
   input  logic   clk,
   input  logic   fastclk,
   input  logic   reset,
   check_if.check chk
);

   localparam int NOMINAL  = `FAST_RATIO * `CLK_WIN;
   // Headroom so the window difference never wraps
   localparam int CNT_BITS = $clog2(NOMINAL + `FAST_TOL) + 1;
   localparam int TMR_BITS = $clog2(`CLK_WIN + 5);
   // Four cycles for the crossing to settle, then the window
   localparam int T_BEGIN  = 3;
   localparam int T_END    = `CLK_WIN + 3;

   // fastclk side
   logic                rst_meta;
   logic                rst_f;
   logic                inj_meta;
   logic                inj_f;
   logic [CNT_BITS-1:0] fcnt;
   logic [CNT_BITS-1:0] gray_f;
   // clk side
   logic [CNT_BITS-1:0] gray_meta;
   logic [CNT_BITS-1:0] gray_s;
   logic [CNT_BITS-1:0] cnt_s;
   logic [CNT_BITS-1:0] t_begin;
   logic [CNT_BITS-1:0] diff;
   logic [TMR_BITS-1:0] timer;
   logic                in_tol;
   logic                running;
   logic                inj;
   logic                pass_q;
   logic                done_q;

   function automatic logic [CNT_BITS-1:0] gray2bin(input logic [CNT_BITS-1:0] g);
      logic [CNT_BITS-1:0] b;
      b[CNT_BITS-1] = g[CNT_BITS-1];
      for (int i = CNT_BITS - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Reset and inject into fastclk
   always_ff @(posedge fastclk) begin
      rst_meta <= reset;
      rst_f    <= rst_meta;
      inj_meta <= inj;
      inj_f    <= inj_meta;
   end

   // Free-running edge counter, frozen by inject
   always_ff @(posedge fastclk) begin
      if (rst_f) begin
         fcnt   <= '0;
         gray_f <= '0;
      end else begin
         if (!inj_f) begin
            fcnt <= fcnt + 1'b1;
         end
         gray_f <= fcnt ^ (fcnt >> 1);
      end
   end

   // Two-flop crossing into clk, then decode
   always_ff @(posedge clk) begin
      gray_meta <= gray_f;
      gray_s    <= gray_meta;
   end

   assign cnt_s  = gray2bin(gray_s);
   assign diff   = cnt_s - t_begin;
   assign in_tol = (diff >= NOMINAL - `FAST_TOL) && (diff <= NOMINAL + `FAST_TOL);

   // Window start sample
   always_ff @(posedge clk) begin
      if (running && timer == TMR_BITS'(T_BEGIN)) begin
         t_begin <= cnt_s;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         running <= 1'b0;
         done_q  <= 1'b0;
         pass_q  <= 1'b0;
         inj     <= 1'b0;
         timer   <= '0;
      end else if (chk.start) begin
         running <= 1'b1;
         done_q  <= 1'b0;
         pass_q  <= 1'b0;
         inj     <= chk.inject;
         timer   <= '0;
      end else if (running) begin
         timer <= timer + 1'b1;
         if (timer == TMR_BITS'(T_END)) begin
            running <= 1'b0;
            done_q  <= 1'b1;
            pass_q  <= in_tol;
         end
      end
   end

   assign chk.done   = done_q;
   assign chk.passed = pass_q;

endmodule

`default_nettype wire

// File: rtl/selftest_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-test sequencer
// Launches all checkers together and folds their results into status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module selftest_ctrl
   import selftest_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          start,
   input  inject_mask_t  inject,
   output logic          busy,
   output logic          done,
   output logic          passed,
   output check_status_t status,
   check_if.ctrl         chk_arith,
   check_if.ctrl         chk_mem,
   check_if.ctrl         chk_clk
);

   ctrl_state_t  state;
   inject_mask_t inj_q;
   logic         launch;
   logic         all_done;

   assign all_done = chk_arith.done && chk_mem.done && chk_clk.done;

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= idle;
         inj_q  <= '0;
         launch <= 1'b0;
         status <= '0;
      end else begin
         launch <= 1'b0;
         case (state)
            // Report counts as idle for a new start
            idle, report: begin
               if (start) begin
                  state  <= run;
                  inj_q  <= inject;
                  launch <= 1'b1;
               end
            end
            run: begin
               // Old done levels still stand during the launch cycle
               if (!launch && all_done) begin
                  status <= {chk_clk.passed, chk_mem.passed, chk_arith.passed};
                  state  <= report;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // Same pulse to all three
   assign chk_arith.start  = launch;
   assign chk_mem.start    = launch;
   assign chk_clk.start    = launch;
   assign chk_arith.inject = inj_q[0];
   assign chk_mem.inject   = inj_q[1];
   assign chk_clk.inject   = inj_q[2];

   assign busy   = (state == run);
   assign done   = (state == report);
   // Overall result is the AND of every checker
   assign passed = done && (&status);

   a_busy_done: assert property (@(posedge clk) disable iff (reset) !(busy && done));

   // Checkers keep their done and passed levels for as long as the report stands
   a_held_results: assert property (@(posedge clk) disable iff (reset)
      done |-> all_done && status == {chk_clk.passed, chk_mem.passed, chk_arith.passed});

endmodule

`default_nettype wire

// File: rtl/selftest_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Power-on self-test top level
// Sequencer plus arithmetic, memory and clock checkers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module selftest_top
   import selftest_pkg::*;
(
   input  logic          clk,
   input  logic          fastclk,
   input  logic          reset,
   input  logic          start,
   input  inject_mask_t  inject,
   output logic          busy,
   output logic          done,
   output logic          passed,
   output check_status_t status
);

   // One link per checker
   check_if chk_arith ();
   check_if chk_mem ();
   check_if chk_clk ();

   selftest_ctrl u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .inject    (inject),
      .busy      (busy),
      .done      (done),
      .passed    (passed),
      .status    (status),
      .chk_arith (chk_arith),
      .chk_mem   (chk_mem),
      .chk_clk   (chk_clk)
   );

   arith_check u_arith (
      .clk   (clk),
      .reset (reset),
      .chk   (chk_arith)
   );

   mem_check u_mem (
      .clk   (clk),
      .reset (reset),
      .chk   (chk_mem)
   );

   // Only checker that sees fastclk
   clk_check u_clk (
      .clk     (clk),
      .fastclk (fastclk),
      .reset   (reset),
      .chk     (chk_clk)
   );

endmodule

`default_nettype wire

// File: bench/selftest_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-test suite testbench
// Runs inject masks from a vector file and checks status and passed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "selftest_defs.svh"

module selftest_tb
   import selftest_pkg::*;
();

   localparam int MAX_VECS = 32;

   logic          clk;
   logic          fastclk;
   logic          reset;
   logic          start;
   inject_mask_t  inject;
   logic          busy;
   logic          done;
   logic          passed;
   check_status_t status;

   // Two words per vector, mask then expected status
   logic [7:0]    vec_words [0:2*MAX_VECS-1];
   int            nvec;
   int            cycles = 0;
   int            cycle_limit = 0;
   // Result still held from the previous run
   logic          have_result;
   check_status_t last_status;

   selftest_top uut (
      .clk     (clk),
      .fastclk (fastclk),
      .reset   (reset),
      .start   (start),
      .inject  (inject),
      .busy    (busy),
      .done    (done),
      .passed  (passed),
      .status  (status)
   );

   // 4 ns clk
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // 1 ns fastclk, four edges per clk
   initial begin
      fastclk = 1'b0;
      forever #0.5 fastclk = ~fastclk;
   end

   task automatic stop_on_failure();
      $display("TEST FAIL");
      $fatal(1, "Stopped at first failure");
   endtask

   // Overall run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: self-test runs did not finish within %0d clock cycles", cycle_limit);
         stop_on_failure();
      end
   end

   task automatic run_vector(input inject_mask_t mask, input check_status_t file_status);
      check_status_t exp_status;
      logic          exp_passed;
      int            gap;
      int            waited;
      bit            poke;
      // A checker passes exactly when its inject bit is clear
      exp_status = ~mask;
      exp_passed = &exp_status;
      assert (file_status == exp_status) else begin
         $display("Vector file lists status %b for mask %b, which should be %b",
                  file_status, mask, exp_status);
         stop_on_failure();
      end
      // Idle gap, old result must stay put
      gap = $urandom_range(15, 0);
      repeat (gap) begin
         @(negedge clk);
         assert (!busy && done == have_result && (!have_result || status == last_status))
         else begin
            $display("Error at %0t ns: held result lost, busy %b done %b status %b",
                     $time, busy, done, status);
            stop_on_failure();
         end
      end
      @(negedge clk);
      start  = 1'b1;
      inject = mask;
      @(negedge clk);
      start  = 1'b0;
      // Inject only counts on the start pulse
      inject = inject_mask_t'($urandom_range(7, 0));
      poke   = bit'($urandom_range(1, 0));
      waited = 1;
      while (!done) begin
         assert (waited <= `SELFTEST_MAX_CYCLES) else begin
            $display("Run with mask %b gave no done within %0d cycles",
                     mask, `SELFTEST_MAX_CYCLES);
            stop_on_failure();
         end
         assert (busy) else begin
            $display("Error at %0t ns: busy low before done", $time);
            stop_on_failure();
         end
         // Start while busy, with the opposite mask
         if (poke && waited == 4) begin
            start  = 1'b1;
            inject = ~mask;
         end else begin
            start = 1'b0;
         end
         @(negedge clk);
         waited++;
      end
      start = 1'b0;
      assert (!busy && status == exp_status && passed == exp_passed) else begin
         $display("Error at %0t ns: mask %b gave busy %b status %b passed %b, expected 0 %b %b",
                  $time, mask, busy, status, passed, exp_status, exp_passed);
         stop_on_failure();
      end
      have_result = 1'b1;
      last_status = exp_status;
   endtask

   initial begin
      int unsigned seed_used;
      int          i;
      seed_used   = $urandom(32'h933f);
      reset       = 1'b1;
      start       = 1'b0;
      inject      = '0;
      have_result = 1'b0;
      last_status = '0;
      // Sentinel marks the end of the vectors
      for (i = 0; i < 2 * MAX_VECS; i++) begin
         vec_words[i] = 8'hff;
      end
      $readmemh("bench/selftest_vectors.txt", vec_words);
      nvec = 0;
      while (nvec < MAX_VECS && vec_words[2*nvec] != 8'hff) begin
         nvec++;
      end
      assert (nvec > 0) else begin
         $display("No vectors found in bench/selftest_vectors.txt");
         stop_on_failure();
      end
      cycle_limit = nvec * (`SELFTEST_MAX_CYCLES + 20);
      repeat (8) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      // Everything quiet out of reset
      assert (!busy && !done && !passed && status == '0) else begin
         $display("Error at %0t ns: after reset busy %b done %b passed %b status %b",
                  $time, busy, done, passed, status);
         stop_on_failure();
      end
      for (i = 0; i < nvec; i++) begin
         run_vector(vec_words[2*i][2:0], vec_words[2*i+1][2:0]);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: selftest_suite.f
+incdir+rtl
rtl/selftest_pkg.sv
rtl/datapath_pkg.sv
rtl/check_if.sv
rtl/arith_check.sv
rtl/mem_check.sv
rtl/clk_check.sv
rtl/selftest_ctrl.sv
rtl/selftest_top.sv
bench/selftest_tb.sv

// File: Bender.yml
package:
  name: selftest_suite

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/selftest_pkg.sv
      - rtl/datapath_pkg.sv
      - rtl/check_if.sv
      - rtl/arith_check.sv
      - rtl/mem_check.sv
      - rtl/clk_check.sv
      - rtl/selftest_ctrl.sv
      - rtl/selftest_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/selftest_tb.sv

// File: bench/selftest_vectors.txt
// Column 1: inject mask, bit 0 arithmetic, bit 1 memory, bit 2 clock
// Column 2: expected status, a checker passes when its inject bit is clear
0 7
1 6
0 7
2 5
0 7
4 3
0 7
3 4
5 2
6 1
7 0
0 7
